// ==== design/uop_pkg.sv ====
package uop_pkg;

    // Physical register tag
    localparam int tag_width = 8;

    // Opcode classes seen by the dispatch router
    typedef enum logic [6:0] {
        opc_alu = 7'b0010011,
        opc_mul = 7'b0110011,
        opc_div = 7'b1001111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_slt  = 4'd5,  // Signed compare
        alu_sltu = 4'd6,
        alu_sll  = 4'd7,
        alu_srl  = 4'd8   // Logical right shift
    } alu_op_e;

    // Renamed micro-op as it leaves rename
    typedef struct packed {
        opcode_e                opcode;
        logic [2:0]             func3;      // Divider variant in RISC-V encoding
        alu_op_e                alu_op;
        logic                   use_imm;    // Operand 2 comes from immediate
        logic [tag_width-1:0]   rd_tag;
        logic [tag_width-1:0]   src1_tag;
        logic [tag_width-1:0]   src2_tag;
        logic [1:0]             src_valid;  // Bit 0 for operand1 and bit 1 for operand2
        logic [31:0]            operand1;
        logic [31:0]            operand2;
        logic [31:0]            immediate;
    } uop_t;

endpackage

// ==== design/exec_pkg.sv ====
package exec_pkg;

    // Number of result buses snooped by every station
    localparam int bus_count = 3;

    localparam int rs_depth = 4;

    // One quotient bit per step
    localparam int div_steps = 32;

    // Result broadcast, one per execution unit
    typedef struct packed {
        logic [uop_pkg::tag_width-1:0] tag;
        logic [31:0]                   value;
    } result_t;

    typedef enum logic [1:0] {
        div_idle,
        div_run,
        div_done
    } div_state_e;

endpackage

// ==== design/dispatch_router.sv ====
`timescale 1ns/10ps

module dispatch_router (
    input  logic          dispatch_valid,
    input  uop_pkg::uop_t dispatch_uop,
    output logic          alu_write,
    output logic          mul_write,
    output logic          div_write
);

    // Only the strobe is steered since every station shares the micro-op bus
    always_comb begin
        alu_write = 1'b0;
        mul_write = 1'b0;
        div_write = 1'b0;
        case (dispatch_uop.opcode)
            uop_pkg::opc_mul: begin
                mul_write = dispatch_valid;
            end
            uop_pkg::opc_div: begin
                div_write = dispatch_valid;
            end
            default: begin
                alu_write = dispatch_valid;  // Unknown opcodes go to the add side
            end
        endcase
    end

endmodule

// ==== design/reservation_station.sv ====
`timescale 1ns/10ps

module reservation_station #(
    parameter int depth = exec_pkg::rs_depth
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              write,
    input  uop_pkg::uop_t     write_uop,
    input  logic [2:0]        wake_valid,
    input  exec_pkg::result_t wake_result [exec_pkg::bus_count],
    input  logic              accept,
    output logic              full,
    output logic              issue_valid,
    output uop_pkg::uop_t     issue_uop
);

    localparam int idx_width = (depth > 1) ? $clog2(depth) : 1;

    uop_pkg::uop_t          slot_uop [depth];
    uop_pkg::uop_t          slot_next [depth];
    uop_pkg::uop_t          write_next;
    logic [depth-1:0]       slot_busy;
    logic [depth-1:0]       older [depth];  // older[j][i] set when slot j is older than i
    logic [depth-1:0]       ready;
    logic [depth-1:0]       is_oldest;
    logic [idx_width-1:0]   issue_sel;
    logic [idx_width-1:0]   free_sel;
    logic                   issue_any;
    logic                   load_issue;
    logic                   write_en;

    // Capture any missing operand whose tag is on a result bus
    function automatic uop_pkg::uop_t snoop(input uop_pkg::uop_t u);
        uop_pkg::uop_t r;
        r = u;
        for (int b = 0; b < exec_pkg::bus_count; b++) begin
            if (wake_valid[b]) begin
                if (!r.src_valid[0] && wake_result[b].tag == r.src1_tag) begin
                    r.operand1     = wake_result[b].value;
                    r.src_valid[0] = 1'b1;
                end
                if (!r.src_valid[1] && wake_result[b].tag == r.src2_tag) begin
                    r.operand2     = wake_result[b].value;
                    r.src_valid[1] = 1'b1;
                end
            end
        end
        return r;
    endfunction

    assign full       = &slot_busy;
    assign write_en   = write && !full;  // Dispatch into a full station is lost
    assign load_issue = !issue_valid || accept;

    always_comb begin
        for (int i = 0; i < depth; i++) begin
            slot_next[i] = snoop(slot_uop[i]);
            ready[i]     = slot_busy[i] && (&slot_uop[i].src_valid);
        end
        write_next = snoop(write_uop);
    end

    always_comb begin
        for (int i = 0; i < depth; i++) begin
            is_oldest[i] = ready[i];
            for (int j = 0; j < depth; j++) begin
                if (ready[j] && older[j][i]) begin
                    is_oldest[i] = 1'b0;
                end
            end
        end
    end

    always_comb begin
        issue_any = 1'b0;
        issue_sel = '0;
        free_sel  = '0;
        for (int i = depth - 1; i >= 0; i--) begin
            if (is_oldest[i]) begin
                issue_any = 1'b1;
                issue_sel = idx_width'(i);
            end
            if (!slot_busy[i]) begin
                free_sel = idx_width'(i);  // Lowest free slot wins
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            slot_busy   <= '0;
            issue_valid <= 1'b0;
            for (int i = 0; i < depth; i++) begin
                older[i] <= '0;
            end
        end else begin
            if (load_issue) begin
                issue_valid <= issue_any;
            end
            if (load_issue && issue_any) begin
                slot_busy[issue_sel] <= 1'b0;
            end
            if (write_en) begin
                slot_busy[free_sel] <= 1'b1;
                older[free_sel]     <= '0;  // Newest entry
                for (int j = 0; j < depth; j++) begin
                    older[j][free_sel] <= slot_busy[j];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < depth; i++) begin
            if (write_en && free_sel == idx_width'(i)) begin
                slot_uop[i] <= write_next;
            end else begin
                slot_uop[i] <= slot_next[i];
            end
        end
        if (load_issue && issue_any) begin
            issue_uop <= slot_uop[issue_sel];
        end
    end

endmodule

// ==== design/int_alu.sv ====
`timescale 1ns/10ps

module int_alu (
    input  logic              clk,
    input  logic              reset,
    input  logic              issue_valid,
    input  uop_pkg::uop_t     issue_uop,
    output logic              accept,
    output logic              result_valid,
    output exec_pkg::result_t result
);

    logic [31:0] src_a;
    logic [31:0] src_b;
    logic [31:0] alu_value;

    assign accept = 1'b1;  // Single cycle unit that never stalls
    assign src_a  = issue_uop.operand1;
    assign src_b  = issue_uop.use_imm ? issue_uop.immediate : issue_uop.operand2;

    always_comb begin
        case (issue_uop.alu_op)
            uop_pkg::alu_add:  alu_value = src_a + src_b;
            uop_pkg::alu_sub:  alu_value = src_a - src_b;
            uop_pkg::alu_and:  alu_value = src_a & src_b;
            uop_pkg::alu_or:   alu_value = src_a | src_b;
            uop_pkg::alu_xor:  alu_value = src_a ^ src_b;
            uop_pkg::alu_slt:  alu_value = {31'd0, $signed(src_a) < $signed(src_b)};
            uop_pkg::alu_sltu: alu_value = {31'd0, src_a < src_b};
            uop_pkg::alu_sll:  alu_value = src_a << src_b[4:0];
            uop_pkg::alu_srl:  alu_value = src_a >> src_b[4:0];
            default:           alu_value = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        result.tag   <= issue_uop.rd_tag;
        result.value <= alu_value;
    end

endmodule

// ==== design/mul_unit.sv ====
`timescale 1ns/10ps

module mul_unit (
    input  logic              clk,
    input  logic              reset,
    input  logic              issue_valid,
    input  uop_pkg::uop_t     issue_uop,
    output logic              accept,
    output logic              result_valid,
    output exec_pkg::result_t result
);

    logic                          s1_valid;
    logic [uop_pkg::tag_width-1:0] s1_tag;
    logic [31:0]                   s1_a;
    logic [31:0]                   s1_b;
    logic                          s2_valid;
    exec_pkg::result_t             s2;  // Tag with low product word

    assign accept = 1'b1;  // Fully pipelined

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid     <= 1'b0;
            s2_valid     <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            s1_valid     <= issue_valid;
            s2_valid     <= s1_valid;
            result_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_tag   <= issue_uop.rd_tag;
        s1_a     <= issue_uop.operand1;
        s1_b     <= issue_uop.operand2;
        s2.tag   <= s1_tag;
        s2.value <= s1_a * s1_b;  // Upper word is dropped
        result   <= s2;
    end

endmodule

// ==== design/div_unit.sv ====
`timescale 1ns/10ps

module div_unit (
    input  logic              clk,
    input  logic              reset,
    input  logic              issue_valid,
    input  uop_pkg::uop_t     issue_uop,
    output logic              accept,
    output logic              result_valid,
    output exec_pkg::result_t result
);

    localparam int step_width = $clog2(exec_pkg::div_steps);

    exec_pkg::div_state_e          state_q;
    logic [step_width-1:0]         step_q;
    logic [uop_pkg::tag_width-1:0] tag_q;
    logic [31:0]                   divisor_q;
    logic [31:0]                   quo_q;
    logic [31:0]                   rem_q;
    logic                          neg_quo_q;
    logic                          neg_rem_q;
    logic                          want_rem_q;
    logic                          is_signed;
    logic                          start;
    logic                          div_zero;
    logic [31:0]                   a_mag;
    logic [31:0]                   b_mag;
    logic [32:0]                   shifted;
    logic [32:0]                   diff;

    // func3 bit 0 marks unsigned and bit 1 selects the remainder
    assign is_signed = !issue_uop.func3[0];
    assign accept    = (state_q == exec_pkg::div_idle);
    assign start     = accept && issue_valid;
    assign div_zero  = (issue_uop.operand2 == 32'd0);

    assign a_mag = (is_signed && issue_uop.operand1[31]) ? -issue_uop.operand1
                                                         : issue_uop.operand1;
    assign b_mag = (is_signed && issue_uop.operand2[31]) ? -issue_uop.operand2
                                                         : issue_uop.operand2;

    // Restoring step
    assign shifted = {rem_q, quo_q[31]};
    assign diff    = shifted - {1'b0, divisor_q};

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q      <= exec_pkg::div_idle;
            step_q       <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            case (state_q)
                exec_pkg::div_idle: begin
                    if (start && div_zero) begin
                        result_valid <= 1'b1;  // Answer is known at once
                    end else if (start) begin
                        state_q <= exec_pkg::div_run;
                        step_q  <= step_width'(exec_pkg::div_steps - 1);
                    end
                end
                exec_pkg::div_run: begin
                    step_q <= step_q - 1'b1;
                    if (step_q == '0) begin
                        state_q <= exec_pkg::div_done;
                    end
                end
                default: begin
                    result_valid <= 1'b1;
                    state_q      <= exec_pkg::div_idle;
                end
            endcase
        end
    end

    // Most negative over minus one takes the normal path
    // Its magnitude quotient 0x80000000 needs no sign correction
    always_ff @(posedge clk) begin
        case (state_q)
            exec_pkg::div_idle: begin
                tag_q      <= issue_uop.rd_tag;
                divisor_q  <= b_mag;
                quo_q      <= a_mag;
                rem_q      <= '0;
                neg_quo_q  <= is_signed && (issue_uop.operand1[31] ^ issue_uop.operand2[31]);
                neg_rem_q  <= is_signed && issue_uop.operand1[31];
                want_rem_q <= issue_uop.func3[1];
                if (start && div_zero) begin
                    result.tag   <= issue_uop.rd_tag;
                    result.value <= issue_uop.func3[1] ? issue_uop.operand1 : 32'hffff_ffff;
                end
            end
            exec_pkg::div_run: begin
                if (!diff[32]) begin
                    rem_q <= diff[31:0];
                    quo_q <= {quo_q[30:0], 1'b1};
                end else begin
                    rem_q <= shifted[31:0];
                    quo_q <= {quo_q[30:0], 1'b0};
                end
            end
            default: begin
                result.tag <= tag_q;
                if (want_rem_q) begin
                    result.value <= neg_rem_q ? -rem_q : rem_q;
                end else begin
                    result.value <= neg_quo_q ? -quo_q : quo_q;
                end
            end
        endcase
    end

endmodule

// ==== design/exec_cluster.sv ====
`timescale 1ns/10ps

module exec_cluster (
    input  logic              clk,
    input  logic              reset,
    input  logic              dispatch_valid,
    input  uop_pkg::uop_t     dispatch_uop,
    output logic              alu_full,
    output logic              mul_full,
    output logic              div_full,
    output logic              alu_result_valid,
    output exec_pkg::result_t alu_result,
    output logic              mul_result_valid,
    output exec_pkg::result_t mul_result,
    output logic              div_result_valid,
    output exec_pkg::result_t div_result
);

    logic              alu_write;
    logic              mul_write;
    logic              div_write;
    logic              alu_issue_valid;
    logic              mul_issue_valid;
    logic              div_issue_valid;
    uop_pkg::uop_t     alu_issue_uop;
    uop_pkg::uop_t     mul_issue_uop;
    uop_pkg::uop_t     div_issue_uop;
    logic              alu_accept;
    logic              mul_accept;
    logic              div_accept;
    logic [2:0]        wake_valid;
    exec_pkg::result_t wake_result [exec_pkg::bus_count];

    // Every station snoops every result bus
    assign wake_valid     = {div_result_valid, mul_result_valid, alu_result_valid};
    assign wake_result[0] = alu_result;
    assign wake_result[1] = mul_result;
    assign wake_result[2] = div_result;

    dispatch_router dispatch_router_inst (
        .dispatch_valid (dispatch_valid),
        .dispatch_uop   (dispatch_uop),
        .alu_write      (alu_write),
        .mul_write      (mul_write),
        .div_write      (div_write)
    );

    reservation_station alu_rs (
        .clk (clk), .reset (reset), .write (alu_write), .write_uop (dispatch_uop),
        .wake_valid (wake_valid), .wake_result (wake_result), .accept (alu_accept),
        .full (alu_full), .issue_valid (alu_issue_valid), .issue_uop (alu_issue_uop)
    );

    reservation_station mul_rs (
        .clk (clk), .reset (reset), .write (mul_write), .write_uop (dispatch_uop),
        .wake_valid (wake_valid), .wake_result (wake_result), .accept (mul_accept),
        .full (mul_full), .issue_valid (mul_issue_valid), .issue_uop (mul_issue_uop)
    );

    reservation_station div_rs (
        .clk (clk), .reset (reset), .write (div_write), .write_uop (dispatch_uop),
        .wake_valid (wake_valid), .wake_result (wake_result), .accept (div_accept),
        .full (div_full), .issue_valid (div_issue_valid), .issue_uop (div_issue_uop)
    );

    int_alu int_alu_inst (
        .clk (clk), .reset (reset), .issue_valid (alu_issue_valid),
        .issue_uop (alu_issue_uop), .accept (alu_accept),
        .result_valid (alu_result_valid), .result (alu_result)
    );

    mul_unit mul_unit_inst (
        .clk (clk), .reset (reset), .issue_valid (mul_issue_valid),
        .issue_uop (mul_issue_uop), .accept (mul_accept),
        .result_valid (mul_result_valid), .result (mul_result)
    );

    div_unit div_unit_inst (
        .clk (clk), .reset (reset), .issue_valid (div_issue_valid),
        .issue_uop (div_issue_uop), .accept (div_accept),
        .result_valid (div_result_valid), .result (div_result)
    );

endmodule

// ==== dv/exec_cluster_table.svh ====
`ifndef exec_cluster_table_svh
`define exec_cluster_table_svh

task automatic fill_table();
    // ALU columns are operation, use_imm, operand1, operand2, immediate, rd_tag, expected
    alu_row(uop_pkg::alu_add,  1'b0, 32'h0000_0005, 32'h0000_0007, 32'h0, 8'd1, 32'h0000_000c);
    alu_row(uop_pkg::alu_add,  1'b1, 32'h0000_1000, 32'h99, 32'hffff_fff0, 8'd2, 32'h0000_0ff0);
    alu_row(uop_pkg::alu_sub,  1'b0, 32'h0000_000a, 32'h0000_000f, 32'h0, 8'd3, 32'hffff_fffb);
    alu_row(uop_pkg::alu_and,  1'b0, 32'hf0f0_1234, 32'h0ff0_ff00, 32'h0, 8'd4, 32'h00f0_1200);
    alu_row(uop_pkg::alu_or,   1'b1, 32'h1200_0000, 32'h77, 32'h0000_0034, 8'd5, 32'h1200_0034);
    alu_row(uop_pkg::alu_xor,  1'b0, 32'haaaa_5555, 32'hffff_0000, 32'h0, 8'd6, 32'h5555_5555);
    alu_row(uop_pkg::alu_slt,  1'b0, 32'hffff_ffff, 32'h0000_0001, 32'h0, 8'd7, 32'h0000_0001);
    alu_row(uop_pkg::alu_sltu, 1'b0, 32'hffff_ffff, 32'h0000_0001, 32'h0, 8'd8, 32'h0000_0000);
    alu_row(uop_pkg::alu_sltu, 1'b1, 32'h0000_0005, 32'h0, 32'hffff_fffb, 8'd9, 32'h0000_0001);
    alu_row(uop_pkg::alu_sll,  1'b0, 32'h0000_0003, 32'h0000_0024, 32'h0, 8'd10, 32'h0000_0030);
    alu_row(uop_pkg::alu_srl,  1'b1, 32'h8000_0000, 32'h1, 32'h0000_001f, 8'd11, 32'h0000_0001);
    alu_row(uop_pkg::alu_srl,  1'b0, 32'hf000_0000, 32'h0000_0008, 32'h0, 8'd12, 32'h00f0_0000);

    // Multiply columns are operand1, operand2, rd_tag and the low product word
    mul_row(32'h0000_0007, 32'h0000_0006, 8'd20, 32'h0000_002a);
    mul_row(32'h1234_5678, 32'h0000_0010, 8'd21, 32'h2345_6780);
    mul_row(32'hffff_ffff, 32'hffff_ffff, 8'd22, 32'h0000_0001);
    mul_row(32'h0001_0000, 32'h0001_0000, 8'd23, 32'h0000_0000);
    mul_row(32'h8000_0000, 32'h0000_0003, 8'd24, 32'h8000_0000);
    mul_row(32'h0000_ffff, 32'h0000_ffff, 8'd25, 32'hfffe_0001);

    // Divide columns are func3 (4 div, 5 divu, 6 rem, 7 remu), dividend, divisor,
    // rd_tag and expected
    div_row(3'd4, 32'h0000_0064, 32'h0000_0007, 8'd30, 32'h0000_000e);
    div_row(3'd4, 32'hffff_ff9c, 32'h0000_0007, 8'd31, 32'hffff_fff2);
    div_row(3'd6, 32'hffff_ff9c, 32'h0000_0007, 8'd32, 32'hffff_fffe);
    div_row(3'd5, 32'hffff_ff9c, 32'h0000_0007, 8'd33, 32'h2492_4916);
    div_row(3'd7, 32'hffff_ff9c, 32'h0000_0007, 8'd34, 32'h0000_0002);
    div_row(3'd6, 32'h0000_0064, 32'hffff_fff9, 8'd35, 32'h0000_0002);
    div_row(3'd4, 32'hffff_ff9c, 32'hffff_fff9, 8'd36, 32'h0000_000e);
    div_row(3'd4, 32'h8000_0000, 32'hffff_ffff, 8'd37, 32'h8000_0000);  // Overflow
    div_row(3'd6, 32'h8000_0000, 32'hffff_ffff, 8'd38, 32'h0000_0000);
    div_row(3'd4, 32'h0000_04d2, 32'h0000_0000, 8'd39, 32'hffff_ffff);  // Divide by zero
    div_row(3'd5, 32'h0000_0055, 32'h0000_0000, 8'd40, 32'hffff_ffff);
    div_row(3'd6, 32'hffff_fff7, 32'h0000_0000, 8'd41, 32'hffff_fff7);
    div_row(3'd7, 32'h8000_0001, 32'h0000_0000, 8'd42, 32'h8000_0001);

    // Chained columns are opcode, func3, alu_op, src_valid, src1_tag, src2_tag,
    // operand1, operand2, rd_tag and expected
    chained_row(uop_pkg::opc_alu, 3'd0, uop_pkg::alu_add, 2'b10, 8'd37, 8'd0,
                32'h0, 32'h0000_0005, 8'd50, 32'h8000_0005);
    chained_row(uop_pkg::opc_mul, 3'd0, uop_pkg::alu_add, 2'b10, 8'd50, 8'd0,
                32'h0, 32'h0000_0002, 8'd51, 32'h0000_000a);
    chained_row(uop_pkg::opc_div, 3'd5, uop_pkg::alu_add, 2'b01, 8'd0, 8'd51,
                32'hffff_fffe, 32'h0, 8'd52, 32'h1999_9999);
    chained_row(uop_pkg::opc_alu, 3'd0, uop_pkg::alu_sub, 2'b00, 8'd52, 8'd39,
                32'h0, 32'h0, 8'd53, 32'h1999_999a);
endtask

`endif

// ==== dv/exec_cluster_tb.sv ====
`timescale 1ns/10ps

module exec_cluster_tb;

    localparam int tag_count = 1 << uop_pkg::tag_width;

    typedef logic [uop_pkg::tag_width-1:0] tag_t;

    typedef struct packed {
        uop_pkg::opcode_e opcode;
        logic [2:0]       func3;
        uop_pkg::alu_op_e alu_op;
        logic             use_imm;
        logic [31:0]      operand1;
        logic [31:0]      operand2;
        logic [31:0]      immediate;
        logic [1:0]       src_valid;
        tag_t             src1_tag;
        tag_t             src2_tag;
        tag_t             rd_tag;
        logic [31:0]      expected;
        logic             hold;  // Sources come from earlier rows by tag
    } row_t;

    logic              clk;
    logic              reset;
    logic              dispatch_valid;
    uop_pkg::uop_t     dispatch_uop;
    logic              alu_full;
    logic              mul_full;
    logic              div_full;
    logic              alu_result_valid;
    exec_pkg::result_t alu_result;
    logic              mul_result_valid;
    exec_pkg::result_t mul_result;
    logic              div_result_valid;
    exec_pkg::result_t div_result;

    row_t              rows [$];
    int                tag_row [tag_count];  // Row index per rd_tag, -1 if unused
    logic              got_seen [tag_count];
    logic [31:0]       got_value [tag_count];
    int                pass_count;
    int                fail_count;
    int                error_count;
    int                done_count;
    logic              table_ready;
    logic              div_stall_seen;

    exec_cluster exec_cluster_inst (
        .clk              (clk),
        .reset            (reset),
        .dispatch_valid   (dispatch_valid),
        .dispatch_uop     (dispatch_uop),
        .alu_full         (alu_full),
        .mul_full         (mul_full),
        .div_full         (div_full),
        .alu_result_valid (alu_result_valid),
        .alu_result       (alu_result),
        .mul_result_valid (mul_result_valid),
        .mul_result       (mul_result),
        .div_result_valid (div_result_valid),
        .div_result       (div_result)
    );

    always #4 clk = ~clk;  // 8 ns period

    task automatic store_row(input uop_pkg::opcode_e opcode, input logic [2:0] func3,
                             input uop_pkg::alu_op_e alu_op, input logic use_imm,
                             input logic [31:0] a, input logic [31:0] b,
                             input logic [31:0] imm, input logic [1:0] src_valid,
                             input tag_t src1_tag, input tag_t src2_tag, input tag_t rd_tag,
                             input logic [31:0] expected, input logic hold);
        row_t row;
        row.opcode    = opcode;
        row.func3     = func3;
        row.alu_op    = alu_op;
        row.use_imm   = use_imm;
        row.operand1  = a;
        row.operand2  = b;
        row.immediate = imm;
        row.src_valid = src_valid;
        row.src1_tag  = src1_tag;
        row.src2_tag  = src2_tag;
        row.rd_tag    = rd_tag;
        row.expected  = expected;
        row.hold      = hold;
        tag_row[rd_tag] = rows.size();
        rows.push_back(row);
    endtask

    task automatic alu_row(input uop_pkg::alu_op_e op, input logic use_imm,
                           input logic [31:0] a, input logic [31:0] b, input logic [31:0] imm,
                           input tag_t tag, input logic [31:0] expected);
        store_row(uop_pkg::opc_alu, 3'd0, op, use_imm, a, b, imm, 2'b11, '0, '0, tag,
                  expected, 1'b0);
    endtask

    task automatic mul_row(input logic [31:0] a, input logic [31:0] b, input tag_t tag,
                           input logic [31:0] expected);
        store_row(uop_pkg::opc_mul, 3'd0, uop_pkg::alu_add, 1'b0, a, b, 32'd0, 2'b11, '0, '0,
                  tag, expected, 1'b0);
    endtask

    task automatic div_row(input logic [2:0] func3, input logic [31:0] a, input logic [31:0] b,
                           input tag_t tag, input logic [31:0] expected);
        store_row(uop_pkg::opc_div, func3, uop_pkg::alu_add, 1'b0, a, b, 32'd0, 2'b11, '0, '0,
                  tag, expected, 1'b0);
    endtask

    task automatic chained_row(input uop_pkg::opcode_e opcode, input logic [2:0] func3,
                               input uop_pkg::alu_op_e op, input logic [1:0] src_valid,
                               input tag_t src1_tag, input tag_t src2_tag,
                               input logic [31:0] a, input logic [31:0] b, input tag_t tag,
                               input logic [31:0] expected);
        store_row(opcode, func3, op, 1'b0, a, b, 32'd0, src_valid, src1_tag, src2_tag, tag,
                  expected, 1'b1);
    endtask

    `include "exec_cluster_table.svh"

    // Bus 0 is the ALU, bus 1 the multiplier and bus 2 the divider
    function automatic int expected_bus(input uop_pkg::opcode_e opcode);
        case (opcode)
            uop_pkg::opc_mul: return 1;
            uop_pkg::opc_div: return 2;
            default:          return 0;
        endcase
    endfunction

    function automatic logic station_full(input uop_pkg::opcode_e opcode);
        logic [2:0] fulls;
        fulls = {div_full, mul_full, alu_full};
        return fulls[expected_bus(opcode)];
    endfunction

    function automatic uop_pkg::uop_t build_uop(input row_t row);
        uop_pkg::uop_t u;
        u.opcode    = row.opcode;
        u.func3     = row.func3;
        u.alu_op    = row.alu_op;
        u.use_imm   = row.use_imm;
        u.rd_tag    = row.rd_tag;
        u.src1_tag  = row.src1_tag;
        u.src2_tag  = row.src2_tag;
        u.src_valid = row.src_valid;
        u.operand1  = row.operand1;
        u.operand2  = row.operand2;
        u.immediate = row.immediate;
        // Rename hands over the value of a producer that already broadcast
        if (row.hold) begin
            if (!u.src_valid[0] && got_seen[u.src1_tag]) begin
                u.operand1     = got_value[u.src1_tag];
                u.src_valid[0] = 1'b1;
            end
            if (!u.src_valid[1] && got_seen[u.src2_tag]) begin
                u.operand2     = got_value[u.src2_tag];
                u.src_valid[1] = 1'b1;
            end
        end
        return u;
    endfunction

    task automatic check_idle();
        assert (!alu_result_valid && !mul_result_valid && !div_result_valid
                && !alu_full && !mul_full && !div_full) else begin
            error_count++;
            $display("A result strobe or full flag is high at %0t around reset", $time);
        end
    endtask

    task automatic record_result(input int bus, input exec_pkg::result_t r);
        int row;
        row = tag_row[r.tag];
        if (row < 0) begin
            error_count++;
            $display("Result with unknown tag %0d on bus %0d at %0t", r.tag, bus, $time);
        end else if (got_seen[r.tag]) begin
            error_count++;
            $display("Tag %0d was broadcast a second time at %0t", r.tag, $time);
        end else begin
            got_seen[r.tag]  = 1'b1;
            got_value[r.tag] = r.value;
            done_count++;
            assert (bus == expected_bus(rows[row].opcode)) else begin
                error_count++;
                $display("Tag %0d came back on bus %0d, not on its own unit's bus", r.tag, bus);
            end
            assert (r.value === rows[row].expected) begin
                pass_count++;
                $display("Row %0d tag %0d done with %h", row, r.tag, r.value);
            end else begin
                fail_count++;
                $display("Fail at %0t: result value for tag %0d expected %h actual %h",
                         $time, r.tag, rows[row].expected, r.value);
            end
        end
    endtask

    task automatic print_summary();
        $display("Rows passed: %0d, rows failed: %0d, other errors: %0d",
                 pass_count, fail_count, error_count);
    endtask

    // Results are stable at the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            if (alu_result_valid) record_result(0, alu_result);
            if (mul_result_valid) record_result(1, mul_result);
            if (div_result_valid) record_result(2, div_result);
        end
    end

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_uop   = '0;
        pass_count     = 0;
        fail_count     = 0;
        error_count    = 0;
        done_count     = 0;
        div_stall_seen = 1'b0;
        for (int t = 0; t < tag_count; t++) begin
            tag_row[t]   = -1;
            got_seen[t]  = 1'b0;
            got_value[t] = '0;
        end
        fill_table();
        table_ready = 1'b1;

        repeat (16) begin
            @(negedge clk);
            check_idle();
        end
        reset = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_idle();
        end

        foreach (rows[i]) begin
            while (station_full(rows[i].opcode)) begin
                dispatch_valid = 1'b0;  // Upstream holds while the station is full
                if (rows[i].opcode == uop_pkg::opc_div) begin
                    div_stall_seen = 1'b1;
                end
                @(negedge clk);
            end
            dispatch_uop   = build_uop(rows[i]);
            dispatch_valid = 1'b1;
            @(negedge clk);
        end
        dispatch_valid = 1'b0;

        while (done_count < rows.size()) begin
            @(negedge clk);
        end
        repeat (40) @(negedge clk);  // Room for a late duplicate

        assert (div_stall_seen) else begin
            error_count++;
            $display("div_full never rose during the divide burst");
        end

        print_summary();
        if (fail_count == 0 && error_count == 0 && pass_count == rows.size()) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        longint limit;
        wait (table_ready === 1'b1);
        limit = rows.size() * 60 * 8;  // 60 cycles of 8 ns per row
        #(limit);
        foreach (rows[i]) begin
            if (!got_seen[rows[i].rd_tag]) begin
                $display("No result arrived for row %0d, tag %0d", i, rows[i].rd_tag);
            end
        end
        $display("Run stopped by the watchdog after %0d ns", limit);
        print_summary();
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== project.f ====
design/uop_pkg.sv
design/exec_pkg.sv
design/dispatch_router.sv
design/reservation_station.sv
design/int_alu.sv
design/mul_unit.sv
design/div_unit.sv
design/exec_cluster.sv
+incdir+dv
dv/exec_cluster_tb.sv
